// File: common/trace_pkg.sv
`default_nettype none

package trace_pkg;

    ////////////////////////////////////////
    // Pipeline event types
    ////////////////////////////////////////

    typedef logic [15:0] cycle_t;      // Cycle stamp, wraps around
    typedef logic [31:0] instr_t;      // Fetched instruction word
    typedef logic [3:0]  stall_cnt_t;  // Stall cycles, saturating

    parameter stall_cnt_t STALL_MAX = 4'd15;   // Saturation point of stall counts

    parameter int TRACE_DEPTH_DEFAULT = 32;    // In-flight entries

    ////////////////////////////////////////
    // Stamp slots in pipeline order
    ////////////////////////////////////////

    parameter int NUM_STAMPS  = 9;
    parameter int STG_FETCH   = 0;   // Also the slot of the tail pointer
    parameter int STG_IF_ID   = 1;
    parameter int STG_DECODE  = 2;
    parameter int STG_ID_EX   = 3;
    parameter int STG_EXECUTE = 4;
    parameter int STG_EX_MEM  = 5;
    parameter int STG_MEM     = 6;
    parameter int STG_MEM_WB  = 7;
    parameter int STG_WB      = 8;

endpackage

`default_nettype wire

// File: common/trace_fmt_pkg.sv
`default_nettype none

package trace_fmt_pkg;

    ////////////////////////////////////////
    // Output record layout
    ////////////////////////////////////////

    typedef logic [31:0] trace_word_t;  // One record word
    typedef logic [2:0]  word_idx_t;    // Word position within a record

    parameter int REC_WORDS = 6;

    // Stamp pairs hold the older stamp in the upper half
    parameter word_idx_t WORD_INSTR      = 3'd0;
    parameter word_idx_t WORD_FETCH_IFID = 3'd1;
    parameter word_idx_t WORD_DEC_IDEX   = 3'd2;
    parameter word_idx_t WORD_EX_EXMEM   = 3'd3;
    parameter word_idx_t WORD_MEM_MEMWB  = 3'd4;
    parameter word_idx_t WORD_WB_FLAGS   = 3'd5;

    // Flag field in the lower half of the last word
    parameter int FLAG_FLUSH_BIT = 15;
    parameter int FLAG_STALL_LSB = 0;   // Stall count in bits 3..0

endpackage

`default_nettype wire

// File: hw/cycle_timer.sv
`default_nettype none

module cycle_timer (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   stall,
    output trace_pkg::cycle_t     cycle_now,
    output logic                  stall_done,
    output trace_pkg::stall_cnt_t stall_len
);
    import trace_pkg::*;

    stall_cnt_t run_cnt;  // Length of the current stall run

    ////////////////////////////////////////
    // Free-running stamp
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_now <= '0;
        end else begin
            cycle_now <= cycle_now + 1'b1;  // Wraps at 16 bits
        end
    end

    ////////////////////////////////////////
    // Stall run length
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_cnt    <= '0;
            stall_done <= 1'b0;
            stall_len  <= '0;
        end else begin
            if (stall) begin
                if (run_cnt != STALL_MAX) begin
                    run_cnt <= run_cnt + 1'b1;
                end
            end else begin
                run_cnt <= '0;
            end
            // First low sample after a run closes it
            stall_done <= !stall && (run_cnt != '0);
            stall_len  <= run_cnt;
        end
    end

endmodule

`default_nettype wire

// File: trace_store/stage_tracker.sv
`default_nettype none

module stage_tracker #(
    parameter  int DEPTH = trace_pkg::TRACE_DEPTH_DEFAULT,
    localparam int AW    = $clog2(DEPTH),
    localparam int PW    = AW + 1
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           fetch,
    input  wire           if_id,
    input  wire           decode,
    input  wire           id_ex,
    input  wire           execute,
    input  wire           ex_mem,
    input  wire           mem,
    input  wire           mem_wb,
    input  wire           wb,
    input  wire           flush,
    input  wire           pop,
    output logic          we_fetch,
    output logic [AW-1:0] addr_fetch,
    output logic          we_if_id,
    output logic [AW-1:0] addr_if_id,
    output logic          we_decode,
    output logic [AW-1:0] addr_decode,
    output logic          we_id_ex,
    output logic [AW-1:0] addr_id_ex,
    output logic          we_execute,
    output logic [AW-1:0] addr_execute,
    output logic          we_ex_mem,
    output logic [AW-1:0] addr_ex_mem,
    output logic          we_mem,
    output logic [AW-1:0] addr_mem,
    output logic          we_mem_wb,
    output logic [AW-1:0] addr_mem_wb,
    output logic          we_wb,
    output logic [AW-1:0] addr_wb,
    output logic          flush_we,
    output logic [AW-1:0] flush_addr,
    output logic [AW-1:0] stall_addr,
    output logic [PW-1:0] wb_ptr,
    output logic [PW-1:0] head_ptr,
    output logic          overflow
);
    import trace_pkg::*;

    logic [PW-1:0]         ptr [NUM_STAMPS];  // Tail, then one per stage
    logic [PW-1:0]         head;
    logic [PW-1:0]         ex_next;           // Execute pointer after this edge
    logic [NUM_STAMPS-1:0] stb;
    logic [NUM_STAMPS-1:0] hit;               // Strobe with an eligible entry
    logic                  full;

    assign stb  = {wb, mem_wb, mem, ex_mem, execute, id_ex, decode, if_id, fetch};
    assign full = (ptr[STG_FETCH] - head) == PW'(DEPTH);

    ////////////////////////////////////////
    // Eligibility
    ////////////////////////////////////////

    // A stage may only take an entry the previous stage has already seen
    always_comb begin
        hit[STG_FETCH] = stb[STG_FETCH] && !flush && !full;
        for (int s = 1; s < NUM_STAMPS; s++) begin
            hit[s] = stb[s] && (ptr[s] != ptr[s-1]) && !(flush && s <= STG_ID_EX);
        end
    end

    assign ex_next = ptr[STG_EXECUTE] + PW'(hit[STG_EXECUTE]);

    ////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < NUM_STAMPS; s++) begin
                ptr[s] <= '0;
            end
            head     <= '0;
            overflow <= 1'b0;
        end else begin
            for (int s = 0; s < NUM_STAMPS; s++) begin
                if (flush && s <= STG_ID_EX) begin
                    ptr[s] <= ex_next;  // Younger entries are dropped
                end else if (hit[s]) begin
                    ptr[s] <= ptr[s] + PW'(1);
                end
            end
            if (pop) begin
                head <= head + PW'(1);
            end
            if (fetch && !flush && full) begin
                overflow <= 1'b1;  // Sticky
            end
        end
    end

    assign we_fetch     = hit[STG_FETCH];
    assign addr_fetch   = ptr[STG_FETCH][AW-1:0];
    assign we_if_id     = hit[STG_IF_ID];
    assign addr_if_id   = ptr[STG_IF_ID][AW-1:0];
    assign we_decode    = hit[STG_DECODE];
    assign addr_decode  = ptr[STG_DECODE][AW-1:0];
    assign we_id_ex     = hit[STG_ID_EX];
    assign addr_id_ex   = ptr[STG_ID_EX][AW-1:0];
    assign we_execute   = hit[STG_EXECUTE];
    assign addr_execute = ptr[STG_EXECUTE][AW-1:0];
    assign we_ex_mem    = hit[STG_EX_MEM];
    assign addr_ex_mem  = ptr[STG_EX_MEM][AW-1:0];
    assign we_mem       = hit[STG_MEM];
    assign addr_mem     = ptr[STG_MEM][AW-1:0];
    assign we_mem_wb    = hit[STG_MEM_WB];
    assign addr_mem_wb  = ptr[STG_MEM_WB][AW-1:0];
    assign we_wb        = hit[STG_WB];
    assign addr_wb      = ptr[STG_WB][AW-1:0];

    // Youngest survivor of a flush gets the mark
    assign flush_we   = flush;
    assign flush_addr = ex_next[AW-1:0] - AW'(1);
    assign stall_addr = ptr[STG_DECODE][AW-1:0];
    assign wb_ptr     = ptr[STG_WB];
    assign head_ptr   = head;

endmodule

`default_nettype wire

// File: trace_store/trace_queue.sv
`default_nettype none

module trace_queue #(
    parameter  int DEPTH = trace_pkg::TRACE_DEPTH_DEFAULT,
    localparam int AW    = $clog2(DEPTH)
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire trace_pkg::instr_t     instr,
    input  wire trace_pkg::cycle_t     cycle_now,
    input  wire                        we_fetch,
    input  wire [AW-1:0]               addr_fetch,
    input  wire                        we_if_id,
    input  wire [AW-1:0]               addr_if_id,
    input  wire                        we_decode,
    input  wire [AW-1:0]               addr_decode,
    input  wire                        we_id_ex,
    input  wire [AW-1:0]               addr_id_ex,
    input  wire                        we_execute,
    input  wire [AW-1:0]               addr_execute,
    input  wire                        we_ex_mem,
    input  wire [AW-1:0]               addr_ex_mem,
    input  wire                        we_mem,
    input  wire [AW-1:0]               addr_mem,
    input  wire                        we_mem_wb,
    input  wire [AW-1:0]               addr_mem_wb,
    input  wire                        we_wb,
    input  wire [AW-1:0]               addr_wb,
    input  wire                        flush_we,
    input  wire [AW-1:0]               flush_addr,
    input  wire                        stall_done,
    input  wire trace_pkg::stall_cnt_t stall_len,
    input  wire [AW-1:0]               stall_addr,
    input  wire [AW-1:0]               rd_addr,
    output trace_pkg::instr_t          rd_instr,
    output trace_pkg::cycle_t          rd_stamp [trace_pkg::NUM_STAMPS],
    output trace_pkg::stall_cnt_t      rd_stall,
    output logic                       rd_flush
);
    import trace_pkg::*;

    logic [NUM_STAMPS-1:0] we_v;
    logic [AW-1:0]         addr_v [NUM_STAMPS];
    instr_t                instr_mem [DEPTH];
    cycle_t                stamp_mem [NUM_STAMPS][DEPTH];
    stall_cnt_t            stall_mem [DEPTH];
    logic [DEPTH-1:0]      flush_mem;
    logic [4:0]            stall_sum;  // One bit of headroom

    assign we_v = {we_wb, we_mem_wb, we_mem, we_ex_mem, we_execute,
                   we_id_ex, we_decode, we_if_id, we_fetch};
    assign addr_v = '{addr_fetch, addr_if_id, addr_decode, addr_id_ex, addr_execute,
                      addr_ex_mem, addr_mem, addr_mem_wb, addr_wb};

    ////////////////////////////////////////
    // Instruction and stamp storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (we_v[STG_FETCH]) begin
            instr_mem[addr_v[STG_FETCH]] <= instr;
        end
        for (int s = 0; s < NUM_STAMPS; s++) begin
            if (we_v[s]) begin
                stamp_mem[s][addr_v[s]] <= cycle_now;
            end
        end
    end

    ////////////////////////////////////////
    // Stall count and flush mark
    ////////////////////////////////////////

    assign stall_sum = {1'b0, stall_mem[stall_addr]} + {1'b0, stall_len};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stall_mem[i] <= '0;
            end
            flush_mem <= '0;
        end else begin
            if (stall_done) begin
                stall_mem[stall_addr] <= (stall_sum > 5'(STALL_MAX)) ? STALL_MAX
                                                                     : stall_sum[3:0];
            end
            if (flush_we) begin
                flush_mem[flush_addr] <= 1'b1;
            end
            if (we_fetch) begin  // Fresh entry wins over older updates
                stall_mem[addr_fetch] <= '0;
                flush_mem[addr_fetch] <= 1'b0;
            end
        end
    end

    // Combinational read port
    assign rd_instr = instr_mem[rd_addr];
    assign rd_stall = stall_mem[rd_addr];
    assign rd_flush = flush_mem[rd_addr];

    always_comb begin
        for (int s = 0; s < NUM_STAMPS; s++) begin
            rd_stamp[s] = stamp_mem[s][rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/record_emitter_fsm.sv
`default_nettype none

module record_emitter_fsm #(
    parameter  int DEPTH = trace_pkg::TRACE_DEPTH_DEFAULT,
    localparam int AW    = $clog2(DEPTH),
    localparam int PW    = AW + 1
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire [PW-1:0]               wb_ptr,
    input  wire [PW-1:0]               head_ptr,
    input  wire trace_pkg::instr_t     rd_instr,
    input  wire trace_pkg::cycle_t     rd_stamp [trace_pkg::NUM_STAMPS],
    input  wire trace_pkg::stall_cnt_t rd_stall,
    input  wire                        rd_flush,
    output logic [AW-1:0]              rd_addr,
    output logic                       pop,
    output logic                       rec_valid,
    output trace_fmt_pkg::trace_word_t rec_data,
    output logic                       rec_last
);
    import trace_pkg::*;
    import trace_fmt_pkg::*;

    typedef enum logic {
        EMIT_IDLE,
        EMIT_BUSY
    } emit_state_t;

    emit_state_t state;
    word_idx_t   idx;      // Word being sent, zero while idle
    logic        pending;  // Head entry has retired
    logic [15:0] flags;

    assign rd_addr   = head_ptr[AW-1:0];
    assign pending   = head_ptr != wb_ptr;
    assign rec_valid = (state == EMIT_BUSY) || pending;
    assign rec_last  = rec_valid && (idx == word_idx_t'(REC_WORDS - 1));
    assign pop       = rec_last;

    ////////////////////////////////////////
    // Word sequencing
    ////////////////////////////////////////

    // Word 0 goes out while still idle, so a record starts without delay
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= EMIT_IDLE;
            idx   <= WORD_INSTR;
        end else begin
            case (state)
                EMIT_IDLE: begin
                    if (pending) begin
                        state <= EMIT_BUSY;
                        idx   <= WORD_FETCH_IFID;
                    end
                end
                EMIT_BUSY: begin
                    if (rec_last) begin
                        state <= EMIT_IDLE;  // Next record follows at once if ready
                        idx   <= WORD_INSTR;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                default: begin
                    state <= EMIT_IDLE;
                    idx   <= WORD_INSTR;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Field packing
    ////////////////////////////////////////

    always_comb begin
        flags = '0;
        flags[FLAG_FLUSH_BIT] = rd_flush;
        flags[FLAG_STALL_LSB +: $bits(stall_cnt_t)] = rd_stall;
        case (idx)
            WORD_INSTR:      rec_data = rd_instr;
            WORD_FETCH_IFID: rec_data = {rd_stamp[STG_FETCH], rd_stamp[STG_IF_ID]};
            WORD_DEC_IDEX:   rec_data = {rd_stamp[STG_DECODE], rd_stamp[STG_ID_EX]};
            WORD_EX_EXMEM:   rec_data = {rd_stamp[STG_EXECUTE], rd_stamp[STG_EX_MEM]};
            WORD_MEM_MEMWB:  rec_data = {rd_stamp[STG_MEM], rd_stamp[STG_MEM_WB]};
            WORD_WB_FLAGS:   rec_data = {rd_stamp[STG_WB], flags};
            default:         rec_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/pipe_trace_top.sv
`default_nettype none

module pipe_trace_top #(
    parameter  int DEPTH = trace_pkg::TRACE_DEPTH_DEFAULT,
    localparam int AW    = $clog2(DEPTH),
    localparam int PW    = AW + 1
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        fetch,
    input  wire trace_pkg::instr_t     instr,
    input  wire                        if_id,
    input  wire                        decode,
    input  wire                        id_ex,
    input  wire                        execute,
    input  wire                        ex_mem,
    input  wire                        mem,
    input  wire                        mem_wb,
    input  wire                        wb,
    input  wire                        stall,
    input  wire                        flush,
    output logic                       rec_valid,
    output trace_fmt_pkg::trace_word_t rec_data,
    output logic                       rec_last,
    output logic                       overflow
);
    import trace_pkg::*;

    ////////////////////////////////////////
    // Interconnect
    ////////////////////////////////////////

    cycle_t        cycle_now;
    logic          stall_done;
    stall_cnt_t    stall_len;
    logic [8:0]    we;              // Stage write enables, fetch at bit 0
    logic [AW-1:0] addr [NUM_STAMPS];
    logic          flush_we;
    logic [AW-1:0] flush_addr;
    logic [AW-1:0] stall_addr;
    logic [PW-1:0] wb_ptr;
    logic [PW-1:0] head_ptr;
    logic          pop;
    logic [AW-1:0] rd_addr;
    instr_t        rd_instr;
    cycle_t        rd_stamp [NUM_STAMPS];
    stall_cnt_t    rd_stall;
    logic          rd_flush;

    cycle_timer u_cycle_timer (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .cycle_now  (cycle_now),
        .stall_done (stall_done),
        .stall_len  (stall_len)
    );

    stage_tracker #(.DEPTH(DEPTH)) u_stage_tracker (
        .clk (clk), .rst (rst), .flush (flush), .pop (pop),
        .fetch   (fetch),   .we_fetch   (we[0]), .addr_fetch   (addr[0]),
        .if_id   (if_id),   .we_if_id   (we[1]), .addr_if_id   (addr[1]),
        .decode  (decode),  .we_decode  (we[2]), .addr_decode  (addr[2]),
        .id_ex   (id_ex),   .we_id_ex   (we[3]), .addr_id_ex   (addr[3]),
        .execute (execute), .we_execute (we[4]), .addr_execute (addr[4]),
        .ex_mem  (ex_mem),  .we_ex_mem  (we[5]), .addr_ex_mem  (addr[5]),
        .mem     (mem),     .we_mem     (we[6]), .addr_mem     (addr[6]),
        .mem_wb  (mem_wb),  .we_mem_wb  (we[7]), .addr_mem_wb  (addr[7]),
        .wb      (wb),      .we_wb      (we[8]), .addr_wb      (addr[8]),
        .flush_we   (flush_we),
        .flush_addr (flush_addr),
        .stall_addr (stall_addr),
        .wb_ptr     (wb_ptr),
        .head_ptr   (head_ptr),
        .overflow   (overflow)
    );

    trace_queue #(.DEPTH(DEPTH)) u_trace_queue (
        .clk (clk), .rst (rst), .instr (instr), .cycle_now (cycle_now),
        .we_fetch   (we[0]), .addr_fetch   (addr[0]),
        .we_if_id   (we[1]), .addr_if_id   (addr[1]),
        .we_decode  (we[2]), .addr_decode  (addr[2]),
        .we_id_ex   (we[3]), .addr_id_ex   (addr[3]),
        .we_execute (we[4]), .addr_execute (addr[4]),
        .we_ex_mem  (we[5]), .addr_ex_mem  (addr[5]),
        .we_mem     (we[6]), .addr_mem     (addr[6]),
        .we_mem_wb  (we[7]), .addr_mem_wb  (addr[7]),
        .we_wb      (we[8]), .addr_wb      (addr[8]),
        .flush_we   (flush_we),   .flush_addr (flush_addr),
        .stall_done (stall_done), .stall_len  (stall_len), .stall_addr (stall_addr),
        .rd_addr    (rd_addr),    .rd_instr   (rd_instr),  .rd_stamp   (rd_stamp),
        .rd_stall   (rd_stall),   .rd_flush   (rd_flush)
    );

    record_emitter_fsm #(.DEPTH(DEPTH)) u_record_emitter_fsm (
        .clk       (clk),
        .rst       (rst),
        .wb_ptr    (wb_ptr),
        .head_ptr  (head_ptr),
        .rd_instr  (rd_instr),
        .rd_stamp  (rd_stamp),
        .rd_stall  (rd_stall),
        .rd_flush  (rd_flush),
        .rd_addr   (rd_addr),
        .pop       (pop),
        .rec_valid (rec_valid),
        .rec_data  (rec_data),
        .rec_last  (rec_last)
    );

endmodule

`default_nettype wire

// File: tests/trace_model.svh
`ifndef TRACE_MODEL_SVH
`define TRACE_MODEL_SVH

////////////////////////////////////////
// Expected-record model
////////////////////////////////////////

localparam int MAX_SEQ = 64;  // Instructions fetched over the whole run

logic [31:0] m_instr [MAX_SEQ];
logic [15:0] m_stamp [MAX_SEQ][9];  // Fetch through wb
int          m_done  [MAX_SEQ];     // Stages stamped so far
int          m_stall [MAX_SEQ];
logic        m_flush [MAX_SEQ];
logic        m_dead  [MAX_SEQ];     // Dropped by a flush
int          n_seq       = 0;
int          n_alive     = 0;
int          popped      = 0;       // Records fully sent
int          exp_q [$];             // Retired, record not seen yet
int          stall_run   = 0;
int          charge_len  = 0;
logic        charge_pend = 1'b0;    // Stall run lands on the next edge
logic [15:0] lfsr        = 16'd28;
logic [31:0] rec_words [6];

// Right-shifting Galois form, taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v    = {v[30:0], lfsr[0]};
        lfsr = lfsr_step(lfsr);
    end
    return v;
endfunction

// One rising edge of pipeline events
task automatic model_cycle(input logic [8:0] stb, input logic stl, input logic fl,
                           input logic [31:0] ins, input logic [15:0] stamp);
    int tgt [9];
    int dec_idx;
    int youngest;
    int sum;
    // All choices use the state before the edge
    for (int s = 1; s < 9; s++) begin
        tgt[s] = -1;
        if (stb[s] && !(fl && s <= 3)) begin
            for (int i = n_seq - 1; i >= 0; i--) begin
                if (!m_dead[i] && m_done[i] == s) begin
                    tgt[s] = i;  // Ends on the oldest
                end
            end
        end
    end
    if (charge_pend) begin
        dec_idx = -1;
        for (int i = n_seq - 1; i >= 0; i--) begin
            if (!m_dead[i] && m_done[i] < 3) begin
                dec_idx = i;  // Oldest not yet decoded
            end
        end
        if (dec_idx >= 0) begin
            sum = m_stall[dec_idx] + charge_len;
            m_stall[dec_idx] = (sum > 15) ? 15 : sum;
        end
    end
    for (int s = 1; s < 9; s++) begin
        if (tgt[s] >= 0) begin
            m_stamp[tgt[s]][s] = stamp;
            m_done[tgt[s]]++;
            if (s == 8) begin
                exp_q.push_back(tgt[s]);
            end
        end
    end
    if (stb[0] && !fl && (n_alive - popped) < DEPTH) begin
        m_instr[n_seq]    = ins;
        m_stamp[n_seq][0] = stamp;
        m_done[n_seq]     = 1;
        m_stall[n_seq]    = 0;
        m_flush[n_seq]    = 1'b0;
        m_dead[n_seq]     = 1'b0;
        n_seq++;
        n_alive++;
    end
    if (fl) begin
        youngest = -1;
        for (int i = 0; i < n_seq; i++) begin
            if (!m_dead[i] && m_done[i] < 5) begin
                m_dead[i] = 1'b1;  // Never reached execute
                n_alive--;
            end else if (!m_dead[i]) begin
                youngest = i;
            end
        end
        if (youngest >= 0) begin
            m_flush[youngest] = 1'b1;
        end
    end
    charge_pend = !stl && (stall_run > 0);
    charge_len  = stall_run;
    stall_run   = stl ? ((stall_run < 15) ? stall_run + 1 : 15) : 0;
endtask

task automatic compare_record();
    logic [31:0] want [6];
    int          i;
    checks++;
    assert (exp_q.size() != 0) else begin
        $display("a record was sent while no retired instruction was waiting");
        errors++;
    end
    if (exp_q.size() != 0) begin
        i       = exp_q.pop_front();
        want[0] = m_instr[i];
        want[1] = {m_stamp[i][0], m_stamp[i][1]};
        want[2] = {m_stamp[i][2], m_stamp[i][3]};
        want[3] = {m_stamp[i][4], m_stamp[i][5]};
        want[4] = {m_stamp[i][6], m_stamp[i][7]};
        want[5] = {m_stamp[i][8], m_flush[i], 11'd0, 4'(m_stall[i])};
        for (int w = 0; w < 6; w++) begin
            checks++;
            assert (rec_words[w] === want[w]) else begin
                $display("ERR %0t: instruction %0d word %0d is %h, expected %h",
                         $time, i, w, rec_words[w], want[w]);
                errors++;
            end
        end
    end
endtask

`endif

// File: tests/tb_pipe_trace.sv
`default_nettype none

module tb_pipe_trace;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH           = 32;
    localparam int STROBE_CYCLES   = 200;  // Upper bound over all tests
    localparam int RECORD_COUNT    = 42;
    localparam int WATCHDOG_CYCLES = 2 * (STROBE_CYCLES + 6 * RECORD_COUNT);
    localparam int DRAIN_LIMIT     = 6 * DEPTH + 20;

    logic        clk     = 1'b0;
    logic        rst     = 1'b1;
    logic        fetch   = 1'b0;
    logic [31:0] instr   = '0;
    logic        if_id   = 1'b0;
    logic        decode  = 1'b0;
    logic        id_ex   = 1'b0;
    logic        execute = 1'b0;
    logic        ex_mem  = 1'b0;
    logic        mem     = 1'b0;
    logic        mem_wb  = 1'b0;
    logic        wb      = 1'b0;
    logic        stall   = 1'b0;
    logic        flush   = 1'b0;
    logic        rec_valid;
    logic [31:0] rec_data;
    logic        rec_last;
    logic        overflow;

    logic [15:0] cyc;            // Mirror of the DUT cycle stamp
    int          errors    = 0;
    int          checks    = 0;
    int          word_cnt  = 0;  // Position inside the current record
    int          rec_count = 0;

    `include "trace_model.svh"

    pipe_trace_top #(.DEPTH(DEPTH)) u_pipe_trace_top (
        .clk (clk), .rst (rst), .fetch (fetch), .instr (instr),
        .if_id (if_id), .decode (decode), .id_ex (id_ex), .execute (execute),
        .ex_mem (ex_mem), .mem (mem), .mem_wb (mem_wb), .wb (wb),
        .stall (stall), .flush (flush),
        .rec_valid (rec_valid), .rec_data (rec_data),
        .rec_last (rec_last), .overflow (overflow)
    );

    always #5 clk = ~clk;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Record monitor
    ////////////////////////////////////////

    // A retired record may start once the edge that sampled its wb has passed
    function automatic logic record_due();
        return exp_q.size() != 0 && m_stamp[exp_q[0]][8] != cyc;
    endfunction

    always @(posedge clk) begin
        if (!rst) begin
            checks++;
            assert (rec_valid === (word_cnt != 0 || record_due())) else begin
                $display("ERR %0t: rec_valid is %b at word %0d", $time, rec_valid, word_cnt);
                errors++;
            end
            checks++;
            assert (rec_last === (rec_valid && word_cnt == 5)) else begin
                $display("ERR %0t: rec_last is %b at word %0d", $time, rec_last, word_cnt);
                errors++;
            end
            if (rec_valid) begin
                rec_words[word_cnt] = rec_data;
                if (word_cnt == 5) begin
                    compare_record();
                    word_cnt = 0;
                    popped++;  // Head frees on this edge
                    rec_count++;
                end else begin
                    word_cnt++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    task automatic expect_value(input logic [31:0] got, input logic [31:0] want,
                                input string what);
        checks++;
        assert (got === want) else begin
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic drive_cycle(input logic [8:0] stb, input logic stl, input logic fl);
        logic [31:0] ins;
        @(negedge clk);
        ins = stb[0] ? rand_bits(32) : 32'h0;
        {wb, mem_wb, mem, ex_mem, execute, id_ex, decode, if_id, fetch} = stb;
        instr = ins;
        stall = stl;
        flush = fl;
        model_cycle(stb, stl, fl, ins, cyc);
    endtask

    // Feeds n instructions one stage apart from stage first onward
    task automatic run_pipelined(input int n, input int first);
        logic [8:0] stb;
        for (int t = 0; t < n + 8 - first; t++) begin
            stb = '0;
            for (int s = first; s < 9; s++) begin
                stb[s] = (t >= s - first) && (t < s - first + n);
            end
            drive_cycle(stb, 1'b0, 1'b0);
        end
    endtask

    task automatic drain_records(input string name);
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || word_cnt != 0) && waited < DRAIN_LIMIT) begin
            drive_cycle('0, 1'b0, 1'b0);
            waited++;
        end
        checks++;
        assert (exp_q.size() == 0 && word_cnt == 0) else begin
            $display("%s: %0d records still missing after %0d idle cycles",
                     name, exp_q.size(), waited);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("%-8s finished with %0d errors", name, errors - err_start);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic reset_check();
        int e0;
        e0 = errors;
        repeat (10) begin
            @(negedge clk);
            expect_value(rec_valid, 0, "rec_valid in reset");
            expect_value(rec_last, 0, "rec_last in reset");
            expect_value(overflow, 0, "overflow in reset");
        end
        rst = 1'b0;
        repeat (4) begin
            drive_cycle('0, 1'b0, 1'b0);
            expect_value(rec_valid, 0, "rec_valid after reset");
            expect_value(overflow, 0, "overflow after reset");
        end
        report_test("reset", e0);
    endtask

    task automatic single_instruction();
        int e0;
        int c0;
        e0 = errors;
        c0 = rec_count;
        for (int s = 0; s < 9; s++) begin
            repeat (rand_bits(2)) drive_cycle('0, 1'b0, 1'b0);
            drive_cycle(9'b1 << s, 1'b0, 1'b0);
        end
        drain_records("single");
        expect_value(rec_count - c0, 1, "record count");
        report_test("single", e0);
    endtask

    task automatic overlapped_flow();
        int e0;
        int c0;
        e0 = errors;
        c0 = rec_count;
        run_pipelined(5, 0);  // wb strobes on five straight cycles
        drain_records("overlap");
        expect_value(rec_count - c0, 5, "record count");
        report_test("overlap", e0);
    endtask

    task automatic run_stalled(input int len, input int want);
        drive_cycle(9'h001, 1'b0, 1'b0);
        drive_cycle(9'h002, 1'b0, 1'b0);
        repeat (len) drive_cycle('0, 1'b1, 1'b0);  // Held in decode
        repeat (2) drive_cycle('0, 1'b0, 1'b0);
        for (int s = 2; s < 9; s++) begin
            drive_cycle(9'b1 << s, 1'b0, 1'b0);
        end
        drain_records("stall");
        expect_value(rec_words[5][3:0], want, "stall count");
    endtask

    task automatic stall_counts();
        int e0;
        e0 = errors;
        run_stalled(3, 3);
        run_stalled(20, 15);
        report_test("stall", e0);
    endtask

    task automatic flush_rollback();
        int e0;
        int c0;
        e0 = errors;
        c0 = rec_count;
        drive_cycle(9'h001, 1'b0, 1'b0);
        drive_cycle(9'h003, 1'b0, 1'b0);
        drive_cycle(9'h007, 1'b0, 1'b0);
        drive_cycle(9'h00e, 1'b0, 1'b0);
        drive_cycle(9'h01c, 1'b0, 1'b0);  // Oldest reaches execute
        drive_cycle(9'h020, 1'b0, 1'b1);
        drive_cycle(9'h040, 1'b0, 1'b0);
        drive_cycle(9'h080, 1'b0, 1'b0);
        drive_cycle(9'h100, 1'b0, 1'b0);
        drain_records("flush");
        expect_value(rec_words[5][15], 1, "flush bit of survivor");
        run_pipelined(1, 0);
        drain_records("flush");
        expect_value(rec_words[5][15], 0, "flush bit of next fetch");
        expect_value(rec_count - c0, 2, "record count");
        report_test("flush", e0);
    endtask

    task automatic queue_overflow();
        int e0;
        int c0;
        e0 = errors;
        c0 = rec_count;
        repeat (DEPTH) drive_cycle(9'h001, 1'b0, 1'b0);
        drive_cycle('0, 1'b0, 1'b0);
        expect_value(overflow, 0, "overflow with queue just full");
        drive_cycle(9'h001, 1'b0, 1'b0);  // No room left
        drive_cycle('0, 1'b0, 1'b0);
        expect_value(overflow, 1, "overflow after extra fetch");
        run_pipelined(DEPTH, 1);
        drain_records("overflow");
        expect_value(rec_count - c0, DEPTH, "record count");
        expect_value(overflow, 1, "overflow after retiring");
        report_test("overflow", e0);
    endtask

    initial begin
        reset_check();
        single_instruction();
        overlapped_flow();
        stall_counts();
        flush_rollback();
        queue_overflow();
        $display("tests 6, records %0d, checks %0d, errors %0d", rec_count, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tests
common/trace_pkg.sv
common/trace_fmt_pkg.sv
hw/cycle_timer.sv
trace_store/stage_tracker.sv
trace_store/trace_queue.sv
hw/record_emitter_fsm.sv
hw/pipe_trace_top.sv
tests/tb_pipe_trace.sv
